// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module issue_core_tb --Mdir obj_dir -o issue_core_sim
	./obj_dir/issue_core_sim | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Test FAILED"; exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/issue_core_tb.sv
`timescale 1ns/1ps

module issue_core_tb
	import issue_pkg::*;
();

	localparam int program_len = 20;
	localparam int rob_depth = 8;
	localparam int issue_timeout = 200;
	localparam int commit_timeout = 2000;

	logic clk;
	logic reset;
	logic instr_valid;
	instr_t instr;
	logic instr_ready;
	logic commit_valid;
	commit_t commit;
	logic commit_ready;

	// Program table, filled by load_program
	string names [program_len];
	lc3b_word words [program_len];
	lc3b_word pcs [program_len];
	lc3b_reg dests [program_len];
	lc3b_word values [program_len];
	int entry_count = 0;

	logic [31:0] rng_state = 32'hd072;
	int issued_count = 0;
	int commit_count = 0;
	int mismatches = 0;
	int failures = 0;
	logic timed_out = 1'b0;
	logic full_seen = 1'b0;
	logic hold_pending = 1'b0;
	commit_t held_commit;

	issue_core #(.rob_depth(rob_depth), .alu_stations(3)) u_issue_core (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_ready(instr_ready),
		.commit_valid(commit_valid),
		.commit(commit),
		.commit_ready(commit_ready)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] next_random(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic add_entry(input string name, input lc3b_word word, input lc3b_word pc,
		input lc3b_reg dest, input lc3b_word value);
		names[entry_count] = name;
		words[entry_count] = word;
		pcs[entry_count] = pc;
		dests[entry_count] = dest;
		values[entry_count] = value;
		entry_count++;
	endtask

	// Expected values worked out by hand, all registers start at zero
	task automatic load_program();
		add_entry("add_imm_r1", 16'h1227, 16'h3000, 3'd1, 16'h0007); // R1 = R0 + 7
		add_entry("add_imm_r2_chain", 16'h147d, 16'h3002, 3'd2, 16'h0004); // R2 = R1 - 3
		add_entry("add_reg_r3_chain", 16'h1642, 16'h3004, 3'd3, 16'h000b); // R3 = R1 + R2
		add_entry("and_imm_r4", 16'h58ee, 16'h3006, 3'd4, 16'h000a); // R4 = R3 & 14
		add_entry("not_r5", 16'h9b3f, 16'h3008, 3'd5, 16'hfff5);
		add_entry("lea_r6", 16'hec05, 16'h300a, 3'd6, 16'h3016); // Offset 5
		add_entry("shf_left_r7", 16'hde43, 16'h300c, 3'd7, 16'h0038); // R1 << 3
		add_entry("shf_lrs_r1", 16'hd354, 16'h300e, 3'd1, 16'h0fff); // R5 >> 4 logical
		add_entry("shf_ars_r2", 16'hd572, 16'h3010, 3'd2, 16'hfffd); // R5 >>> 2
		add_entry("add_reg_r3_renamed", 16'h1642, 16'h3012, 3'd3, 16'h0ffc);
		add_entry("lea_neg_r4", 16'he9fc, 16'h3014, 3'd4, 16'h300e); // Offset -4
		add_entry("add_reg_r5_lea", 16'h1b06, 16'h3016, 3'd5, 16'h6024); // R4 + R6
		add_entry("and_reg_r6", 16'h5d47, 16'h3018, 3'd6, 16'h0020); // R5 & R7
		add_entry("add_imm_r7_self", 16'h1ff0, 16'h301a, 3'd7, 16'h0028); // R7 - 16
		add_entry("shf_ars_pos_r1", 16'hd3b3, 16'h301c, 3'd1, 16'h0004); // R6 >>> 3
		add_entry("add_reg_r2", 16'h1447, 16'h301e, 3'd2, 16'h002c); // R1 + R7
		add_entry("not_r3", 16'h96bf, 16'h3020, 3'd3, 16'hffd3);
		add_entry("lea_r0", 16'he040, 16'h3022, 3'd0, 16'h30a4); // Offset 64
		add_entry("add_reg_r4_r0", 16'h1803, 16'h3024, 3'd4, 16'h3077); // R0 + R3
		add_entry("and_imm_r5_zero", 16'h5b20, 16'h3026, 3'd5, 16'h0000);
	endtask

	// Holds one entry on the input until the core takes it
	task automatic issue_entry(input int idx);
		int waited;
		waited = 0;
		instr_valid = 1'b1;
		instr.word = words[idx];
		instr.pc = pcs[idx];
		@(negedge clk);
		while (!instr_ready && !timed_out)
		begin
			waited++;
			if (waited > issue_timeout)
			begin
				$display("Timeout: instruction %s was not accepted within %0d cycles",
					names[idx], issue_timeout);
				failures++;
				timed_out = 1'b1;
			end
			else
				@(negedge clk);
		end
		@(posedge clk); // Accepting edge
		if (!timed_out)
			issued_count++;
		#1;
	endtask

	task automatic wait_for_commits();
		int waited;
		waited = 0;
		while (commit_count < program_len && !timed_out)
		begin
			@(posedge clk);
			waited++;
			if (waited > commit_timeout)
			begin
				$display("Timeout: only %0d of %0d commits arrived within %0d cycles",
					commit_count, program_len, commit_timeout);
				failures++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic check_commit(input int idx);
		assert (commit.dest == dests[idx])
		else
		begin
			$display("MISMATCH %s dest: expected R%0d, actual R%0d",
				names[idx], dests[idx], commit.dest);
			mismatches++;
		end
		assert (commit.value == values[idx])
		else
		begin
			$display("MISMATCH %s value: expected %h, actual %h",
				names[idx], values[idx], commit.value);
			mismatches++;
		end
	endtask

	// Random commit back-pressure
	always @(posedge clk)
	begin
		#1;
		rng_state = next_random(rng_state);
		commit_ready = rng_state[0];
	end

	// Commit monitor, in program order
	always @(negedge clk)
	begin
		if (!reset)
		begin
			// Entries accepted but not yet retired
			if (issued_count - commit_count == rob_depth)
			begin
				full_seen = 1'b1;
				assert (!instr_ready)
				else
				begin
					$display("Instruction ready was high while the ROB held %0d entries",
						rob_depth);
					failures++;
				end
			end
			if (hold_pending)
			begin
				assert (commit_valid && commit == held_commit)
				else
				begin
					$display("Commit output dropped or changed before commit ready was high");
					failures++;
				end
			end
			if (commit_valid && commit_ready)
			begin
				assert (commit_count < program_len)
				else
				begin
					$display("Commit seen after every program entry had already committed");
					failures++;
				end
				if (commit_count < program_len)
					check_commit(commit_count);
				commit_count++;
			end
			hold_pending = commit_valid && !commit_ready;
			held_commit = commit;
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		commit_ready = 1'b0;
		load_program();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		@(negedge clk);
		assert (!commit_valid)
		else
		begin
			$display("MISMATCH reset commit_valid: expected 0, actual %b", commit_valid);
			mismatches++;
		end
		assert (instr_ready)
		else
		begin
			$display("MISMATCH reset instr_ready: expected 1, actual %b", instr_ready);
			mismatches++;
		end
		@(posedge clk);
		#1;

		for (int i = 0; i < program_len && !timed_out; i++)
			issue_entry(i);
		instr_valid = 1'b0;
		instr = '0;

		wait_for_commits();
		repeat (20) @(posedge clk); // Catch any extra commit

		// Program is longer than the ROB, so the ROB must have filled
		assert (full_seen || timed_out)
		else
		begin
			$display("The ROB never held %0d entries during the program", rob_depth);
			failures++;
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: source/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
	import issue_pkg::*;
#(
	parameter int alu_stations = 3
)
(
	input logic clk,
	input logic reset,
	input logic [alu_stations-1:0] station_ready,
	input station_entry_t [alu_stations-1:0] station_held,
	output logic [alu_stations-1:0] grant,
	output cdb_t cdb
);

	station_entry_t pick;
	logic any_ready;
	lc3b_word result;

	// Fixed priority, lowest index first
	always_comb
	begin
		grant = '0;
		pick = station_held[0];
		any_ready = 1'b0;
		for (int i = 0; i < alu_stations; i++)
		begin
			if (station_ready[i] && !any_ready)
			begin
				grant[i] = 1'b1;
				pick = station_held[i];
				any_ready = 1'b1;
			end
		end
	end

	always_comb
	begin
		case (pick.opcode)
			op_add: result = pick.vj + pick.vk;
			op_and: result = pick.vj & pick.vk;
			op_not: result = ~pick.vj;
			op_shf:
				if (!pick.vk[4])
					result = pick.vj << pick.vk[3:0];
				else if (pick.vk[5])
					result = $signed(pick.vj) >>> pick.vk[3:0]; // Arithmetic right
				else
					result = pick.vj >> pick.vk[3:0];
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		cdb.tag <= pick.dest;
		cdb.data <= result;
		if (reset)
			cdb.valid <= 1'b0;
		else
			cdb.valid <= any_ready;
	end

endmodule

// File: source/issue_control.sv
`timescale 1ns/1ps

module issue_control
	import issue_pkg::*;
#(
	parameter int alu_stations = 3
)
(
	input logic instr_valid,
	input instr_t instr,
	output logic instr_ready,
	output lc3b_reg sr1,
	output lc3b_reg sr2,
	input reg_status_t sr1_status,
	input reg_status_t sr2_status,
	input cdb_t cdb,
	input logic rob_full,
	input rob_tag_t free_tag,
	output rob_tag_t lookup_j,
	output rob_tag_t lookup_k,
	input logic j_done,
	input logic k_done,
	input lc3b_word j_value,
	input lc3b_word k_value,
	input logic [alu_stations-1:0] station_busy,
	output logic [alu_stations-1:0] station_write,
	output station_entry_t station_entry,
	output logic rob_alloc,
	output lc3b_reg rob_dest,
	output logic rob_alloc_done,
	output lc3b_word rob_value,
	output logic rename,
	output lc3b_reg rename_reg,
	output rob_tag_t rename_tag
);

	typedef struct packed {
		logic waiting;
		rob_tag_t tag;
		lc3b_word value;
	} operand_t;

	lc3b_word word;
	lc3b_opcode opcode;
	lc3b_reg dest;
	lc3b_word sext5;
	lc3b_word adj9;
	logic is_alu;
	logic is_lea;
	logic accept;
	logic [alu_stations-1:0] free_pick;
	operand_t op_j;
	operand_t op_k;

	// Register value, then same-cycle CDB, then a finished ROB entry
	function automatic operand_t capture(reg_status_t status, cdb_t bus, logic rob_done,
		lc3b_word rob_val);
		operand_t op;
		op = '0;
		if (!status.busy)
			op.value = status.data;
		else if (bus.valid && bus.tag == status.tag)
			op.value = bus.data;
		else if (rob_done)
			op.value = rob_val;
		else
		begin
			op.waiting = 1'b1;
			op.tag = status.tag;
		end
		return op;
	endfunction

	assign word = instr.word;
	assign opcode = lc3b_opcode'(word[15:12]);
	assign dest = word[11:9];
	assign sr1 = word[8:6];
	assign sr2 = word[2:0];
	assign sext5 = {{11{word[4]}}, word[4:0]};
	assign adj9 = {{6{word[8]}}, word[8:0], 1'b0}; // Word offset

	assign is_alu = opcode inside {op_add, op_and, op_not, op_shf};
	assign is_lea = opcode == op_lea;

	// Stall depends on state only
	assign instr_ready = !(rob_full || (is_alu && &station_busy));
	assign accept = instr_valid && instr_ready;

	assign lookup_j = sr1_status.tag;
	assign lookup_k = sr2_status.tag;
	assign op_j = capture(sr1_status, cdb, j_done, j_value);
	assign op_k = capture(sr2_status, cdb, k_done, k_value);

	always_comb
	begin
		free_pick = '0;
		for (int i = 0; i < alu_stations; i++)
		begin
			if (!station_busy[i] && free_pick == '0)
				free_pick[i] = 1'b1; // Lowest free station
		end
	end

	assign station_write = (accept && is_alu) ? free_pick : '0;

	always_comb
	begin
		station_entry = '0;
		station_entry.opcode = opcode;
		station_entry.imm = word[5] || opcode == op_shf;
		station_entry.vj = op_j.value;
		station_entry.qj = op_j.tag;
		station_entry.wait_j = op_j.waiting;
		station_entry.dest = free_tag;
		if (opcode == op_shf)
			station_entry.vk = {10'b0, word[5:0]}; // Shift control and amount
		else if (word[5])
			station_entry.vk = sext5;
		else
		begin
			station_entry.vk = op_k.value;
			station_entry.qk = op_k.tag;
			station_entry.wait_k = op_k.waiting;
		end
	end

	assign rob_alloc = accept;
	assign rob_dest = dest;
	assign rob_alloc_done = is_lea; // LEA needs no execution
	assign rob_value = is_lea ? instr.pc + 16'd2 + adj9 : '0;

	assign rename = accept;
	assign rename_reg = dest;
	assign rename_tag = free_tag;

	always_comb
	begin
		if (accept)
			assert (is_alu || is_lea)
				else $error("Unsupported opcode %b at PC %h", word[15:12], instr.pc);
	end

endmodule

// File: source/issue_core.sv
`timescale 1ns/1ps

module issue_core
	import issue_pkg::*;
#(
	parameter int rob_depth = 8,
	parameter int alu_stations = 3
)
(
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input instr_t instr,
	output logic instr_ready,
	output logic commit_valid,
	output commit_t commit,
	input logic commit_ready
);

	lc3b_reg sr1;
	lc3b_reg sr2;
	reg_status_t sr1_status;
	reg_status_t sr2_status;
	logic rename;
	lc3b_reg rename_reg;
	rob_tag_t rename_tag;
	logic commit_fire;
	rob_tag_t commit_tag;
	logic rob_alloc;
	lc3b_reg rob_dest;
	logic rob_alloc_done;
	lc3b_word rob_value;
	rob_tag_t free_tag;
	logic rob_full;
	rob_tag_t lookup_j;
	rob_tag_t lookup_k;
	logic j_done;
	logic k_done;
	lc3b_word j_value;
	lc3b_word k_value;
	cdb_t cdb;
	logic [alu_stations-1:0] station_busy;
	logic [alu_stations-1:0] station_write;
	logic [alu_stations-1:0] station_ready;
	logic [alu_stations-1:0] grant;
	station_entry_t station_entry;
	station_entry_t [alu_stations-1:0] station_held;

	assign commit_fire = commit_valid && commit_ready;

	register_status u_register_status (
		.clk(clk),
		.reset(reset),
		.sr1(sr1),
		.sr2(sr2),
		.sr1_status(sr1_status),
		.sr2_status(sr2_status),
		.rename(rename),
		.rename_reg(rename_reg),
		.rename_tag(rename_tag),
		.commit_fire(commit_fire),
		.commit(commit),
		.commit_tag(commit_tag)
	);

	reorder_buffer #(.rob_depth(rob_depth)) u_reorder_buffer (
		.clk(clk),
		.reset(reset),
		.alloc(rob_alloc),
		.alloc_dest(rob_dest),
		.alloc_done(rob_alloc_done),
		.alloc_value(rob_value),
		.free_tag(free_tag),
		.full(rob_full),
		.cdb(cdb),
		.lookup_j(lookup_j),
		.lookup_k(lookup_k),
		.j_done(j_done),
		.k_done(k_done),
		.j_value(j_value),
		.k_value(k_value),
		.commit_valid(commit_valid),
		.commit(commit),
		.commit_tag(commit_tag),
		.commit_ready(commit_ready)
	);

	issue_control #(.alu_stations(alu_stations)) u_issue_control (
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_ready(instr_ready),
		.sr1(sr1),
		.sr2(sr2),
		.sr1_status(sr1_status),
		.sr2_status(sr2_status),
		.cdb(cdb),
		.rob_full(rob_full),
		.free_tag(free_tag),
		.lookup_j(lookup_j),
		.lookup_k(lookup_k),
		.j_done(j_done),
		.k_done(k_done),
		.j_value(j_value),
		.k_value(k_value),
		.station_busy(station_busy),
		.station_write(station_write),
		.station_entry(station_entry),
		.rob_alloc(rob_alloc),
		.rob_dest(rob_dest),
		.rob_alloc_done(rob_alloc_done),
		.rob_value(rob_value),
		.rename(rename),
		.rename_reg(rename_reg),
		.rename_tag(rename_tag)
	);

	for (genvar i = 0; i < alu_stations; i++)
	begin : g_station
		reservation_station u_station (
			.clk(clk),
			.reset(reset),
			.write(station_write[i]),
			.entry(station_entry),
			.cdb(cdb),
			.grant(grant[i]),
			.busy(station_busy[i]),
			.ready(station_ready[i]),
			.held(station_held[i])
		);
	end

	alu_unit #(.alu_stations(alu_stations)) u_alu_unit (
		.clk(clk),
		.reset(reset),
		.station_ready(station_ready),
		.station_held(station_held),
		.grant(grant),
		.cdb(cdb)
	);

endmodule

// File: source/issue_pkg.sv
package issue_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// LC-3b opcode field values
	typedef enum logic [3:0] {
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_shf = 4'b1101,
		op_lea = 4'b1110
	} lc3b_opcode;

	localparam int rob_tag_width = 3; // Default ROB depth of 8

	typedef logic [rob_tag_width-1:0] rob_tag_t;

	typedef struct packed {
		lc3b_word word;
		lc3b_word pc;
	} instr_t;

	typedef struct packed {
		logic busy;
		rob_tag_t tag; // Pending writer
		lc3b_word data;
	} reg_status_t;

	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		lc3b_word data;
	} cdb_t;

	typedef struct packed {
		lc3b_reg dest;
		lc3b_word value;
	} commit_t;

	// What a reservation station holds
	typedef struct packed {
		lc3b_opcode opcode;
		logic imm; // Vk came from the instruction
		lc3b_word vj;
		lc3b_word vk;
		rob_tag_t qj;
		rob_tag_t qk;
		logic wait_j;
		logic wait_k;
		rob_tag_t dest;
	} station_entry_t;

endpackage

// File: source/register_status.sv
`timescale 1ns/1ps

module register_status
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input lc3b_reg sr1,
	input lc3b_reg sr2,
	output reg_status_t sr1_status,
	output reg_status_t sr2_status,
	input logic rename,
	input lc3b_reg rename_reg,
	input rob_tag_t rename_tag,
	input logic commit_fire,
	input commit_t commit,
	input rob_tag_t commit_tag
);

	lc3b_word data [8];
	rob_tag_t tag [8];
	logic [7:0] busy;

	assign sr1_status.busy = busy[sr1];
	assign sr1_status.tag = tag[sr1];
	assign sr1_status.data = data[sr1];
	assign sr2_status.busy = busy[sr2];
	assign sr2_status.tag = tag[sr2];
	assign sr2_status.data = data[sr2];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= '0;
			for (int i = 0; i < 8; i++)
			begin
				data[i] <= '0;
				tag[i] <= '0;
			end
		end
		else
		begin
			if (commit_fire)
			begin
				data[commit.dest] <= commit.value;
				// Only the latest writer releases the register
				if (busy[commit.dest] && tag[commit.dest] == commit_tag)
					busy[commit.dest] <= 1'b0;
			end
			if (rename)
			begin
				busy[rename_reg] <= 1'b1; // Overrides a same-cycle release
				tag[rename_reg] <= rename_tag;
			end
		end
	end

endmodule

// File: source/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
	import issue_pkg::*;
#(
	parameter int rob_depth = 8
)
(
	input logic clk,
	input logic reset,
	input logic alloc,
	input lc3b_reg alloc_dest,
	input logic alloc_done,
	input lc3b_word alloc_value,
	output rob_tag_t free_tag,
	output logic full,
	input cdb_t cdb,
	input rob_tag_t lookup_j,
	input rob_tag_t lookup_k,
	output logic j_done,
	output logic k_done,
	output lc3b_word j_value,
	output lc3b_word k_value,
	output logic commit_valid,
	output commit_t commit,
	output rob_tag_t commit_tag,
	input logic commit_ready
);

	localparam logic [rob_tag_width:0] depth_count = rob_depth[rob_tag_width:0];

	lc3b_reg dest [rob_depth];
	lc3b_word value [rob_depth];
	logic [rob_depth-1:0] done;
	rob_tag_t head;
	rob_tag_t tail;
	logic [rob_tag_width:0] count;
	logic retire;
	rob_tag_t cdb_offset; // Distance of the CDB tag from the head

	assign free_tag = tail;
	assign full = count == depth_count;
	assign commit_valid = count != '0 && done[head];
	assign commit.dest = dest[head];
	assign commit.value = value[head];
	assign commit_tag = head;
	assign retire = commit_valid && commit_ready;

	// Operand lookups for issue
	assign j_done = done[lookup_j];
	assign j_value = value[lookup_j];
	assign k_done = done[lookup_k];
	assign k_value = value[lookup_k];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
		end
		else
		begin
			if (alloc)
			begin
				tail <= tail + 1'b1; // Wraps at the power-of-two depth
				done[tail] <= alloc_done;
			end
			if (cdb.valid)
				done[cdb.tag] <= 1'b1;
			if (retire)
				head <= head + 1'b1;
			count <= count + alloc - retire;
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc)
		begin
			dest[tail] <= alloc_dest;
			value[tail] <= alloc_value;
		end
		if (cdb.valid)
			value[cdb.tag] <= cdb.data;
	end

	assign cdb_offset = cdb.tag - head;

	a_alloc_not_full: assert property (@(posedge clk) disable iff (reset) alloc |-> !full)
		else $error("ROB allocate while full");

	// A broadcast must target an entry still in flight
	a_cdb_tag_live: assert property (@(posedge clk) disable iff (reset)
		cdb.valid |-> ({1'b0, cdb_offset} < count && !done[cdb.tag]))
		else $error("CDB tag %0d names no pending ROB entry", cdb.tag);

	a_depth_matches_tag: assert property (@(posedge clk) rob_depth == (1 << rob_tag_width))
		else $error("rob_depth %0d does not match the tag width", rob_depth);

endmodule

// File: source/reservation_station.sv
`timescale 1ns/1ps

module reservation_station
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic write,
	input station_entry_t entry,
	input cdb_t cdb,
	input logic grant,
	output logic busy,
	output logic ready,
	output station_entry_t held
);

	assign ready = busy && !held.wait_j && !held.wait_k;

	always_ff @(posedge clk)
	begin
		if (reset)
			busy <= 1'b0;
		else if (write)
			busy <= 1'b1;
		else if (grant)
			busy <= 1'b0; // Result goes out next cycle
	end

	always_ff @(posedge clk)
	begin
		if (write)
			held <= entry;
		else if (busy && cdb.valid)
		begin
			// Snoop for each missing operand
			if (held.wait_j && cdb.tag == held.qj)
			begin
				held.vj <= cdb.data;
				held.wait_j <= 1'b0;
			end
			if (held.wait_k && cdb.tag == held.qk)
			begin
				held.vk <= cdb.data;
				held.wait_k <= 1'b0;
			end
		end
	end

	a_write_when_free: assert property (@(posedge clk) disable iff (reset) write |-> !busy)
		else $error("Station written while busy");

	// Issue never sends an immediate operand as a tag
	a_imm_not_waiting: assert property (@(posedge clk) disable iff (reset)
		busy |-> !(held.imm && held.wait_k))
		else $error("Immediate station entry waits on Vk");

endmodule

// File: src.f
source/issue_pkg.sv
source/register_status.sv
source/reorder_buffer.sv
source/issue_control.sv
source/reservation_station.sv
source/alu_unit.sv
source/issue_core.sv
sim/issue_core_tb.sv
